// File: logic/rv_pkg.sv
// Shared types for the RV32I multicycle core.
// Opcode values are the RV32I major opcodes. Anything else decodes as illegal.

package rv_pkg;

    localparam int XLEN = 32;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } rv_opcode_e;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } rv_alu_op_e;

    // Sequencer states
    typedef enum logic [1:0] {
        ST_FETCH,
        ST_EXEC,
        ST_MEM,
        ST_HALT
    } rv_state_e;

endpackage

// File: logic/rv_decode.sv
// Integer RV32I decoder, purely combinational.
// Only word loads and stores are legal. ECALL is the only legal SYSTEM word.
// writes_rf_o is never set for rd = x0 or for an illegal instruction.

`timescale 1ns/1ns

module rv_decode import rv_pkg::*; (
    input  logic [31:0] instr_i,
    output rv_opcode_e  opcode_o,
    output logic [4:0]  rs1_o,
    output logic [4:0]  rs2_o,
    output logic [4:0]  rd_o,
    output logic [31:0] imm_o,
    output rv_alu_op_e  alu_op_o,
    output logic        a_is_pc_o,
    output logic        b_is_imm_o,
    output logic        writes_rf_o,
    output logic        is_load_o,
    output logic        is_store_o,
    output logic        is_branch_o,
    output logic        is_jal_o,
    output logic        is_jalr_o,
    output logic        is_ecall_o,
    output logic        is_illegal_o
);

    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i_type;
    logic [31:0] imm_s_type;
    logic [31:0] imm_b_type;
    logic [31:0] imm_u_type;
    logic [31:0] imm_j_type;
    rv_alu_op_e  alu_fn;
    logic        funct7_ok;
    logic        legal;
    logic        writes;

    assign funct3   = instr_i[14:12];
    assign funct7   = instr_i[31:25];
    assign opcode_o = rv_opcode_e'(instr_i[6:0]);
    assign rs1_o    = instr_i[19:15];
    assign rs2_o    = instr_i[24:20];
    assign rd_o     = instr_i[11:7];

    assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u_type = {instr_i[31:12], 12'b0};
    assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};

    // funct3/funct7 to ALU op, shared by OP and OP_IMM
    always_comb begin
        case (funct3)
            3'b000:  alu_fn = (opcode_o == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_fn = ALU_SLL;
            3'b010:  alu_fn = ALU_SLT;
            3'b011:  alu_fn = ALU_SLTU;
            3'b100:  alu_fn = ALU_XOR;
            3'b101:  alu_fn = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_fn = ALU_OR;
            default: alu_fn = ALU_AND;
        endcase
    end

    // Only SUB and SRA may carry funct7 = 0100000
    always_comb begin
        if (opcode_o == OPC_OP_IMM && funct3 != 3'b001 && funct3 != 3'b101) begin
            funct7_ok = 1'b1;  // upper bits are immediate here
        end else if (funct7 == 7'b0000000) begin
            funct7_ok = 1'b1;
        end else if (funct7 == 7'b0100000) begin
            funct7_ok = (funct3 == 3'b101) || (funct3 == 3'b000 && opcode_o == OPC_OP);
        end else begin
            funct7_ok = 1'b0;
        end
    end

    always_comb begin
        legal       = 1'b1;
        writes      = 1'b0;
        imm_o       = imm_i_type;
        alu_op_o    = ALU_ADD;
        a_is_pc_o   = 1'b0;
        b_is_imm_o  = 1'b0;
        is_load_o   = 1'b0;
        is_store_o  = 1'b0;
        is_branch_o = 1'b0;
        is_jal_o    = 1'b0;
        is_jalr_o   = 1'b0;
        is_ecall_o  = 1'b0;
        case (opcode_o)
            OPC_LUI: begin
                writes     = 1'b1;
                imm_o      = imm_u_type;
                alu_op_o   = ALU_PASS_B;
                b_is_imm_o = 1'b1;
            end
            OPC_AUIPC: begin
                writes     = 1'b1;
                imm_o      = imm_u_type;
                a_is_pc_o  = 1'b1;
                b_is_imm_o = 1'b1;
            end
            OPC_JAL: begin
                writes     = 1'b1;
                imm_o      = imm_j_type;
                a_is_pc_o  = 1'b1;
                b_is_imm_o = 1'b1;
                is_jal_o   = 1'b1;
            end
            OPC_JALR: begin
                writes     = 1'b1;
                b_is_imm_o = 1'b1;
                is_jalr_o  = 1'b1;
                legal      = (funct3 == 3'b000);
            end
            OPC_BRANCH: begin
                imm_o       = imm_b_type;
                is_branch_o = 1'b1;
                // Compare op picked by the condition class
                case (funct3)
                    3'b000, 3'b001: alu_op_o = ALU_SUB;
                    3'b100, 3'b101: alu_op_o = ALU_SLT;
                    3'b110, 3'b111: alu_op_o = ALU_SLTU;
                    default:        legal    = 1'b0;
                endcase
            end
            OPC_LOAD: begin
                writes     = 1'b1;
                b_is_imm_o = 1'b1;
                is_load_o  = 1'b1;
                legal      = (funct3 == 3'b010);
            end
            OPC_STORE: begin
                imm_o      = imm_s_type;
                b_is_imm_o = 1'b1;
                is_store_o = 1'b1;
                legal      = (funct3 == 3'b010);
            end
            OPC_OP_IMM: begin
                writes     = 1'b1;
                b_is_imm_o = 1'b1;
                alu_op_o   = alu_fn;
                legal      = funct7_ok;
            end
            OPC_OP: begin
                writes   = 1'b1;
                alu_op_o = alu_fn;
                legal    = funct7_ok;
            end
            OPC_SYSTEM: begin
                is_ecall_o = (instr_i == 32'h0000_0073);
                legal      = is_ecall_o;
            end
            default: legal = 1'b0;
        endcase
        is_illegal_o = !legal;
        writes_rf_o  = writes && legal && (rd_o != 5'd0);
    end

endmodule

// File: logic/rv_regfile.sv
// Register file x1..x31, two async read ports and one sync write port.
// x0 has no storage and reads as zero. Writes to rd = 0 must not be issued.

`timescale 1ns/1ns

module rv_regfile import rv_pkg::*; (
    input  logic            clk_i,
    input  logic [4:0]      rs1_i,
    input  logic [4:0]      rs2_i,
    input  logic [4:0]      rd_i,
    input  logic            we_i,
    input  logic [XLEN-1:0] wdata_i,
    output logic [XLEN-1:0] rs1_data_o,
    output logic [XLEN-1:0] rs2_data_o
);

    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            regs[rd_i] <= wdata_i;
        end
    end

    assign rs1_data_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

    // Decoder is responsible for masking x0 writes
    a_no_x0_write: assert property (@(posedge clk_i) we_i |-> rd_i != 5'd0)
        else $error("register file write to x0");

endmodule

// File: logic/rv_alu.sv
// Operand select, ALU and branch condition, all combinational.
// Branch compares rely on the decoder choosing SUB, SLT or SLTU.

`timescale 1ns/1ns

module rv_alu import rv_pkg::*; (
    input  rv_alu_op_e      alu_op_i,
    input  logic            a_is_pc_i,
    input  logic            b_is_imm_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] rs2_data_i,
    input  logic [XLEN-1:0] imm_i,
    input  logic [2:0]      funct3_i,
    output logic [XLEN-1:0] result_o,
    output logic            branch_taken_o
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;

    assign op_a  = a_is_pc_i ? pc_i : rs1_data_i;
    assign op_b  = b_is_imm_i ? imm_i : rs2_data_i;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op_i)
            ALU_ADD:    result_o = op_a + op_b;
            ALU_SUB:    result_o = op_a - op_b;
            ALU_SLL:    result_o = op_a << shamt;
            ALU_SLT:    result_o = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   result_o = {31'b0, op_a < op_b};
            ALU_XOR:    result_o = op_a ^ op_b;
            ALU_SRL:    result_o = op_a >> shamt;
            ALU_SRA:    result_o = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:     result_o = op_a | op_b;
            ALU_AND:    result_o = op_a & op_b;
            ALU_PASS_B: result_o = op_b;
            default:    result_o = '0;
        endcase
    end

    // funct3[0] inverts the sense: BNE, BGE, BGEU
    always_comb begin
        case (funct3_i[2:1])
            2'b00:   branch_taken_o = (result_o == '0) ^ funct3_i[0];
            default: branch_taken_o = result_o[0] ^ funct3_i[0];
        endcase
    end

endmodule

// File: logic/rv_control.sv
// Fetch/execute sequencer with a Wishbone classic master, one word per transfer.
// A new fetch may start in the cycle right after a data ack.
// Misaligned addresses are not trapped. Halt is left only through reset.

`timescale 1ns/1ns

module rv_control import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  rv_opcode_e      opcode_i,
    input  logic            writes_rf_i,
    input  logic            is_load_i,
    input  logic            is_store_i,
    input  logic            is_branch_i,
    input  logic            is_jal_i,
    input  logic            is_jalr_i,
    input  logic            is_ecall_i,
    input  logic            is_illegal_i,
    input  logic [XLEN-1:0] imm_i,
    input  logic [XLEN-1:0] alu_result_i,
    input  logic            branch_taken_i,
    input  logic [XLEN-1:0] rs2_data_i,
    input  logic [XLEN-1:0] wb_dat_i,
    input  logic            wb_ack_i,
    output logic [31:0]     instr_o,
    output logic [XLEN-1:0] pc_o,
    output logic            rf_we_o,
    output logic [XLEN-1:0] rf_wdata_o,
    output logic            wb_cyc_o,
    output logic            wb_stb_o,
    output logic            wb_we_o,
    output logic [XLEN-1:0] wb_adr_o,
    output logic [XLEN-1:0] wb_dat_o,
    output logic            halt_o,
    output logic            illegal_o
);

    rv_state_e       state;
    logic [XLEN-1:0] pc_q;
    logic [31:0]     instr_q;
    logic            illegal_q;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] next_pc;

    assign pc_plus4 = pc_q + 32'd4;

    always_comb begin
        if (is_jalr_i) begin
            next_pc = {alu_result_i[XLEN-1:1], 1'b0};
        end else if (is_jal_i || (is_branch_i && branch_taken_i)) begin
            next_pc = pc_q + imm_i;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state     <= ST_FETCH;
            pc_q      <= RESET_PC;
            illegal_q <= 1'b0;
        end else begin
            case (state)
                ST_FETCH: if (wb_ack_i) state <= ST_EXEC;
                ST_EXEC: begin
                    if (is_illegal_i || is_ecall_i) begin
                        state     <= ST_HALT;
                        illegal_q <= is_illegal_i;
                    end else begin
                        pc_q  <= next_pc;
                        state <= (is_load_i || is_store_i) ? ST_MEM : ST_FETCH;
                    end
                end
                ST_MEM: if (wb_ack_i) state <= ST_FETCH;
                default: state <= ST_HALT;
            endcase
        end
    end

    // Instruction register
    always_ff @(posedge clk_i) begin
        if (state == ST_FETCH && wb_ack_i) begin
            instr_q <= wb_dat_i;
        end
    end

    // Writeback: load data in MEM, link address for jumps, else ALU
    always_comb begin
        if (state == ST_MEM) begin
            rf_wdata_o = wb_dat_i;
        end else begin
            case (opcode_i)
                OPC_JAL, OPC_JALR: rf_wdata_o = pc_plus4;
                default:           rf_wdata_o = alu_result_i;
            endcase
        end
    end

    assign rf_we_o = (state == ST_EXEC && writes_rf_i && !is_load_i)
                   || (state == ST_MEM && is_load_i && writes_rf_i && wb_ack_i);

    // Bus outputs follow state, so they hold steady while waiting for ack
    assign wb_cyc_o = (state == ST_FETCH) || (state == ST_MEM);
    assign wb_stb_o = wb_cyc_o;
    assign wb_we_o  = (state == ST_MEM) && is_store_i;
    assign wb_adr_o = (state == ST_MEM) ? alu_result_i : pc_q;
    assign wb_dat_o = rs2_data_i;

    assign instr_o   = instr_q;
    assign pc_o      = pc_q;
    assign halt_o    = (state == ST_HALT);
    assign illegal_o = illegal_q;

    // Slave may only acknowledge an open request
    a_ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_ack_i |-> wb_cyc_o && wb_stb_o)
        else $error("wishbone ack outside a bus cycle");

    a_adr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o) && $stable(wb_we_o))
        else $error("wishbone request changed before ack");

endmodule

// File: logic/rv_core.sv
// RV32I multicycle core, top level.
// One Wishbone classic master port carries both fetches and data accesses.
// RESET_PC must be word aligned.

`timescale 1ns/1ns

module rv_core import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    output logic            wb_cyc_o,
    output logic            wb_stb_o,
    output logic            wb_we_o,
    output logic [XLEN-1:0] wb_adr_o,
    output logic [XLEN-1:0] wb_dat_o,
    input  logic [XLEN-1:0] wb_dat_i,
    input  logic            wb_ack_i,
    output logic            halt_o,
    output logic            illegal_o
);

    logic [31:0]     instr;
    logic [XLEN-1:0] pc;
    rv_opcode_e      opcode;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [XLEN-1:0] imm;
    rv_alu_op_e      alu_op;
    logic            a_is_pc;
    logic            b_is_imm;
    logic            writes_rf;
    logic            is_load;
    logic            is_store;
    logic            is_branch;
    logic            is_jal;
    logic            is_jalr;
    logic            is_ecall;
    logic            is_illegal;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] alu_result;
    logic            branch_taken;
    logic            rf_we;
    logic [XLEN-1:0] rf_wdata;

    rv_control #(
        .RESET_PC (RESET_PC)
    ) u_control (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .opcode_i       (opcode),
        .writes_rf_i    (writes_rf),
        .is_load_i      (is_load),
        .is_store_i     (is_store),
        .is_branch_i    (is_branch),
        .is_jal_i       (is_jal),
        .is_jalr_i      (is_jalr),
        .is_ecall_i     (is_ecall),
        .is_illegal_i   (is_illegal),
        .imm_i          (imm),
        .alu_result_i   (alu_result),
        .branch_taken_i (branch_taken),
        .rs2_data_i     (rs2_data),
        .wb_dat_i       (wb_dat_i),
        .wb_ack_i       (wb_ack_i),
        .instr_o        (instr),
        .pc_o           (pc),
        .rf_we_o        (rf_we),
        .rf_wdata_o     (rf_wdata),
        .wb_cyc_o       (wb_cyc_o),
        .wb_stb_o       (wb_stb_o),
        .wb_we_o        (wb_we_o),
        .wb_adr_o       (wb_adr_o),
        .wb_dat_o       (wb_dat_o),
        .halt_o         (halt_o),
        .illegal_o      (illegal_o)
    );

    rv_decode u_decode (
        .instr_i      (instr),
        .opcode_o     (opcode),
        .rs1_o        (rs1),
        .rs2_o        (rs2),
        .rd_o         (rd),
        .imm_o        (imm),
        .alu_op_o     (alu_op),
        .a_is_pc_o    (a_is_pc),
        .b_is_imm_o   (b_is_imm),
        .writes_rf_o  (writes_rf),
        .is_load_o    (is_load),
        .is_store_o   (is_store),
        .is_branch_o  (is_branch),
        .is_jal_o     (is_jal),
        .is_jalr_o    (is_jalr),
        .is_ecall_o   (is_ecall),
        .is_illegal_o (is_illegal)
    );

    rv_regfile u_regfile (
        .clk_i      (clk_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rd_i       (rd),
        .we_i       (rf_we),
        .wdata_i    (rf_wdata),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    // funct3 comes straight from the instruction register
    rv_alu u_alu (
        .alu_op_i       (alu_op),
        .a_is_pc_i      (a_is_pc),
        .b_is_imm_i     (b_is_imm),
        .pc_i           (pc),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .imm_i          (imm),
        .funct3_i       (instr[14:12]),
        .result_o       (alu_result),
        .branch_taken_o (branch_taken)
    );

endmodule

// File: sim/tb_wb_mem.sv
// Wishbone classic slave memory, word access only, 0 to 3 random wait states.
// Address wraps on the array depth. Outputs change 2 ns after the clock edge.

`timescale 1ns/1ns

module tb_wb_mem #(
    parameter int          DEPTH = 1024,
    parameter logic [31:0] SEED  = 32'd30
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        cyc_i,
    input  logic        stb_i,
    input  logic        we_i,
    input  logic [31:0] adr_i,
    input  logic [31:0] dat_i,
    output logic [31:0] dat_o,
    output logic        ack_o
);

    localparam int AW = $clog2(DEPTH);

    logic [31:0]   mem [0:DEPTH-1];
    logic [31:0]   lcg_state;
    logic [1:0]    waits;
    logic          req;
    logic          rst_seen;
    logic          wr;
    logic [AW-1:0] idx;
    logic [31:0]   wdata;

    function automatic logic [1:0] rand_wait();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:30];
    endfunction

    initial begin
        lcg_state = SEED;
        ack_o     = 1'b0;
        waits     = 2'd0;
    end

    assign dat_o = mem[adr_i[AW+1:2]];

    always @(posedge clk_i) begin
        // Sample the request at the edge, respond a little later
        req      = cyc_i && stb_i && !ack_o;
        rst_seen = !rst_n_i;
        wr       = we_i;
        idx      = adr_i[AW+1:2];
        wdata    = dat_i;
        #2;
        if (rst_seen) begin
            ack_o = 1'b0;
            waits = rand_wait();
        end else if (ack_o) begin
            ack_o = 1'b0;
            waits = rand_wait();
        end else if (req) begin
            if (waits == 2'd0) begin
                ack_o = 1'b1;
                if (wr) begin
                    mem[idx] = wdata;
                end
            end else begin
                waits = waits - 2'd1;
            end
        end
    end

endmodule

// File: sim/rv_model.svh
// Program generator and RV32I reference model, included inside the testbench.
// Loads and stores use x0 as base so every address is a known constant.
// Branches and jumps only go forward, so every program reaches its end.

`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                      logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
endfunction

function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

// Spec ALU, alt selects SUB or SRA
function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                        logic [31:0] b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3:    return (a < b) ? 32'd1 : 32'd0;
        3'd4:    return a ^ b;
        3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

task automatic gen_program(input bit end_illegal);
    logic [31:0] r;
    logic [31:0] r2;
    logic [31:0] word;
    logic [11:0] imm;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [2:0]  kind;
    logic [6:0]  f7;
    int          k;
    for (int a = 0; a < MEM_WORDS; a++) begin
        exp_mem[a] = 32'(a) * 32'h9E37_79B9 ^ 32'h5A5A_0000;
    end
    for (int i = 0; i < 64; i++) begin
        exp_mem[DATA_ADDR / 4 + i] = rand_word();
    end
    // Preamble gives every register a known value
    for (int n = 1; n < 32; n++) begin
        r = rand_word();
        exp_mem[n - 1] = enc_i(r[31:20], 5'd0, 3'd0, 5'(n), OPC_OP_IMM);
    end
    for (int s = 0; s < BODY_LEN; s++) begin
        r    = rand_word();
        r2   = rand_word();
        rd   = r[12:8];
        rs1  = r[17:13];
        rs2  = r[22:18];
        f3   = r[25:23];
        k    = 1 + int'(r[27:26]) % 3;
        kind = r[30:28];
        if (kind >= 3'd6 && s + k + 1 > BODY_LEN) begin
            kind = 3'd0;
        end
        case (kind)
            3'd0, 3'd1: begin
                f7   = ((f3 == 3'd0 || f3 == 3'd5) && r[31]) ? 7'h20 : 7'h00;
                word = enc_r(f7, rs2, rs1, f3, rd, OPC_OP);
            end
            3'd2: begin
                imm = r2[11:0];
                if (f3 == 3'd1) begin
                    imm = {7'h00, r2[4:0]};
                end else if (f3 == 3'd5) begin
                    imm = {1'b0, r[31], 5'b0, r2[4:0]};
                end
                word = enc_i(imm, rs1, f3, rd, OPC_OP_IMM);
            end
            3'd3: begin
                if (r[31]) begin
                    word = {r2[31:12], rd, OPC_LUI};
                end else begin
                    word = {r2[31:12], rd, OPC_AUIPC};
                end
            end
            3'd4: begin
                imm  = 12'(DATA_ADDR) + {4'b0, r2[5:0], 2'b00};
                word = enc_i(imm, 5'd0, 3'b010, rd, OPC_LOAD);
            end
            3'd5: begin
                imm  = 12'(DATA_ADDR) + {4'b0, r2[5:0], 2'b00};
                word = enc_s(imm, rs2, 5'd0);
            end
            3'd6: begin
                f3 = r2[2:0];
                if (f3 == 3'd2 || f3 == 3'd3) begin
                    f3 = f3 + 3'd2;
                end
                // Same register on both sides makes the equal case likely
                word = enc_b(13'(4 * (k + 1)), r[31] ? rs1 : rs2, rs1, f3);
            end
            default: begin
                if (r[31]) begin
                    word = enc_j(21'(4 * (k + 1)), rd);
                end else begin
                    word = enc_i(12'(4 * (PRE_LEN + s + k + 1)), 5'd0, 3'd0, rd, OPC_JALR);
                end
            end
        endcase
        exp_mem[PRE_LEN + s] = word;
    end
    for (int n = 0; n < 32; n++) begin
        exp_mem[PRE_LEN + BODY_LEN + n] = enc_s(12'(DUMP_ADDR + 4 * n), 5'(n), 5'd0);
    end
    r = rand_word();
    exp_mem[PRE_LEN + BODY_LEN + 32] = end_illegal ? {r[31:7], 7'b0001011} : 32'h0000_0073;
endtask

// Runs the program in exp_mem, returns 1 when it stops on an illegal word
function automatic bit run_model();
    logic [31:0] x [0:31];
    logic [31:0] pc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] npc;
    logic [4:0]  rd;
    logic [2:0]  f3;
    bit          taken;
    for (int i = 0; i < 32; i++) begin
        x[i] = '0;
    end
    pc = '0;
    for (int step = 0; step < 4 * PROG_WORDS; step++) begin
        w   = exp_mem[pc[AW+1:2]];
        rd  = w[11:7];
        f3  = w[14:12];
        a   = x[w[19:15]];
        b   = x[w[24:20]];
        npc = pc + 32'd4;
        case (w[6:0])
            OPC_LUI:   x[rd] = {w[31:12], 12'b0};
            OPC_AUIPC: x[rd] = pc + {w[31:12], 12'b0};
            OPC_JAL: begin
                x[rd] = pc + 32'd4;
                npc   = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            OPC_JALR: begin
                npc   = (a + {{20{w[31]}}, w[31:20]}) & ~32'd1;
                x[rd] = pc + 32'd4;
            end
            OPC_BRANCH: begin
                case (f3)
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = ($signed(a) < $signed(b));
                    3'd5:    taken = ($signed(a) >= $signed(b));
                    3'd6:    taken = (a < b);
                    default: taken = (a >= b);
                endcase
                if (taken) begin
                    npc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            OPC_LOAD: x[rd] = exp_mem[(a + {{20{w[31]}}, w[31:20]}) >> 2];
            OPC_STORE: exp_mem[(a + {{20{w[31]}}, w[31:25], w[11:7]}) >> 2] = b;
            OPC_OP_IMM: x[rd] = alu_ref(f3, f3 == 3'd5 && w[30], a, {{20{w[31]}}, w[31:20]});
            OPC_OP:     x[rd] = alu_ref(f3, w[30], a, b);
            OPC_SYSTEM: return (w != 32'h0000_0073);
            default:    return 1'b1;
        endcase
        x[0] = '0;
        pc   = npc;
    end
    return 1'b1;
endfunction

`endif

// File: sim/rv_core_tb.sv
// Random-program testbench for rv_core, checked against an ISA model.
// Each program resets the core, runs to halt, then compares the whole memory.
// The last two programs end in an illegal word instead of ECALL.

`timescale 1ns/1ns

module rv_core_tb import rv_pkg::*; ();

    localparam int  MEM_WORDS  = 1024;
    localparam int  AW         = 10;
    localparam int  NUM_PROGS  = 12;
    localparam int  PRE_LEN    = 31;
    localparam int  BODY_LEN   = 40;
    localparam int  PROG_WORDS = PRE_LEN + BODY_LEN + 33;
    localparam int  DATA_ADDR  = 'h600;
    localparam int  DUMP_ADDR  = 'h700;
    localparam int  CLK_PERIOD = 40;
    localparam longint TIMEOUT_NS = longint'(NUM_PROGS) * (PROG_WORDS * 10 + 10) * CLK_PERIOD;

    logic        clk_i;
    logic        rst_n_i;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        halt_o;
    logic        illegal_o;

    logic [31:0] exp_mem [0:MEM_WORDS-1];
    logic [31:0] seed = 32'd30;
    int          mem_errors;
    int          status_errors;
    bit          exp_illegal;

    function automatic logic [31:0] rand_word();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    `include "rv_model.svh"

    rv_core #(
        .RESET_PC (32'h0)
    ) dut0 (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .wb_cyc_o  (wb_cyc),
        .wb_stb_o  (wb_stb),
        .wb_we_o   (wb_we),
        .wb_adr_o  (wb_adr),
        .wb_dat_o  (wb_dat_w),
        .wb_dat_i  (wb_dat_r),
        .wb_ack_i  (wb_ack),
        .halt_o    (halt_o),
        .illegal_o (illegal_o)
    );

    tb_wb_mem #(
        .DEPTH (MEM_WORDS),
        .SEED  (32'd30)
    ) mem0 (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .cyc_i   (wb_cyc),
        .stb_i   (wb_stb),
        .we_i    (wb_we),
        .adr_i   (wb_adr),
        .dat_i   (wb_dat_w),
        .dat_o   (wb_dat_r),
        .ack_o   (wb_ack)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the core did not halt in time");
        $display("Finished with errors");
        $finish;
    end

    task automatic wait_halt();
        do begin
            @(posedge clk_i);
            #1;
        end while (!halt_o);
    endtask

    task automatic check_result(input int prog, input bit illegal_exp);
        if (illegal_o !== illegal_exp) begin
            $display("Fail prog%0d illegal_o: expected %0d, actual %0d",
                     prog, illegal_exp, illegal_o);
            status_errors++;
        end
        // The halted core must stay off the bus
        repeat (4) begin
            @(posedge clk_i);
            #1;
            if (wb_cyc || wb_stb) begin
                $display("Program %0d started a bus cycle after halt", prog);
                status_errors++;
            end
        end
        for (int a = 0; a < MEM_WORDS; a++) begin
            if (mem0.mem[a] !== exp_mem[a]) begin
                $display("Fail prog%0d mem[0x%03h]: expected %h, actual %h",
                         prog, a * 4, exp_mem[a], mem0.mem[a]);
                mem_errors++;
            end
        end
    endtask

    initial begin
        rst_n_i       = 1'b0;
        mem_errors    = 0;
        status_errors = 0;
        for (int prog = 0; prog < NUM_PROGS; prog++) begin
            @(posedge clk_i);
            #2;
            rst_n_i = 1'b0;
            gen_program(prog >= NUM_PROGS - 2);
            for (int a = 0; a < MEM_WORDS; a++) begin
                mem0.mem[a] = exp_mem[a];
            end
            exp_illegal = run_model();
            repeat (2) @(posedge clk_i);
            #2;
            rst_n_i = 1'b1;
            wait_halt();
            check_result(prog, exp_illegal);
        end
        $display("Ran %0d programs: %0d memory errors, %0d status errors",
                 NUM_PROGS, mem_errors, status_errors);
        if (mem_errors == 0 && status_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+sim
logic/rv_pkg.sv
logic/rv_decode.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_control.sv
logic/rv_core.sv
sim/tb_wb_mem.sv
sim/rv_core_tb.sv

// File: Makefile
# Verilator flow for the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Finished with no errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
